//--- verilog/axi_ctrl_pkg.sv
// address map, data widths, request region and engine state types
`default_nettype none

package axi_ctrl_pkg;

    typedef logic [14:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [2:0]  mb_index_t;

    // where a decoded request lands
    typedef enum logic [1:0] {
        REGION_MB,
        REGION_AA,
        REGION_UNSUPP,
        REGION_IGNORE
    } region_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_RESPOND,
        ST_IRQ
    } engine_state_t;

    // ----------------------------------------
    // local register map
    // ----------------------------------------
    localparam addr_t MB_LOW   = 15'h2000;
    localparam addr_t MB_HIGH  = 15'h201F;
    localparam addr_t AA_LOW   = 15'h2100;
    localparam addr_t AA_HIGH  = 15'h2107;
    localparam addr_t WIN_HIGH = 15'h2FFF;

    localparam word_t UNSUPP_DATA = 32'hFFFF_FFFF;

    localparam int FIFO_DEPTH_DEFAULT = 8;

    // stream write, two beats
    localparam logic [1:0] SS_WR_USER = 2'b01;

endpackage

`default_nettype wire

//--- verilog/ctrl_req_if.sv
// decoded request channel between a request port and the engine
`timescale 1ns/1ps
`default_nettype none

interface ctrl_req_if;

    logic                    valid;
    logic                    write;
    axi_ctrl_pkg::region_t   region;
    axi_ctrl_pkg::mb_index_t index;
    axi_ctrl_pkg::word_t     data;
    axi_ctrl_pkg::strb_t     strb;
    // one cycle, consumes the request
    logic                    taken;

    modport port (
        output valid, write, region, index, data, strb,
        input  taken
    );

    modport engine (
        input  valid, write, region, index, data, strb,
        output taken
    );

endinterface

`default_nettype wire

//--- verilog/req_fifo.sv
// circular buffer queue with valid/ready on the write and read sides
`timescale 1ns/1ps
`default_nettype none

module req_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 8
) (
    input  wire              axi_aclk,
    input  wire              axi_aresetn,
    input  wire              wr_vld,
    input  wire [WIDTH-1:0]  wr_data,
    output logic             wr_rdy,
    output logic             rd_vld,
    output logic [WIDTH-1:0] rd_data,
    input  wire              rd_rdy
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign wr_rdy  = (count != CNT_W'(DEPTH));
    assign rd_vld  = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign push    = wr_vld && wr_rdy;
    assign pop     = rd_vld && rd_rdy;

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    a_no_write_when_full : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn) wr_vld |-> wr_rdy
    );

endmodule

`default_nettype wire

//--- verilog/ls_request_port.sv
// local strobe queue with region decode of the head request
`timescale 1ns/1ps
`default_nettype none

module ls_request_port #(
    parameter int FIFO_DEPTH = axi_ctrl_pkg::FIFO_DEPTH_DEFAULT
) (
    input  wire                 axi_aclk,
    input  wire                 axi_aresetn,
    input  wire                 wstart,
    input  wire axi_ctrl_pkg::addr_t waddr,
    input  wire axi_ctrl_pkg::word_t wdata,
    input  wire axi_ctrl_pkg::strb_t wstrb,
    input  wire                 rstart,
    input  wire axi_ctrl_pkg::addr_t raddr,
    ctrl_req_if.port            req
);

    // entry layout {write, addr, data, strb}
    localparam int ENTRY_W = 1 + $bits(axi_ctrl_pkg::addr_t) + $bits(axi_ctrl_pkg::word_t)
                             + $bits(axi_ctrl_pkg::strb_t);

    logic [ENTRY_W-1:0]  entry_in;
    logic [ENTRY_W-1:0]  entry_out;
    logic                fifo_wr_rdy;
    logic                head_write;
    axi_ctrl_pkg::addr_t head_addr;
    logic                in_win;
    logic                in_mb;
    logic                in_aa;

    // reads carry no payload
    assign entry_in = wstart ? {1'b1, waddr, wdata, wstrb} : {1'b0, raddr, 32'h0, 4'h0};

    req_fifo #(
        .WIDTH (ENTRY_W),
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_vld      (wstart || rstart),
        .wr_data     (entry_in),
        .wr_rdy      (fifo_wr_rdy),
        .rd_vld      (req.valid),
        .rd_data     (entry_out),
        .rd_rdy      (req.taken)
    );

    assign {head_write, head_addr, req.data, req.strb} = entry_out;
    assign req.write = head_write;
    assign req.index = head_addr[4:2];

    // ----------------------------------------
    // head decode
    // ----------------------------------------
    assign in_win = (head_addr >= axi_ctrl_pkg::MB_LOW) && (head_addr <= axi_ctrl_pkg::WIN_HIGH);
    assign in_mb  = in_win && (head_addr <= axi_ctrl_pkg::MB_HIGH);
    assign in_aa  = in_win && (head_addr >= axi_ctrl_pkg::AA_LOW)
                           && (head_addr <= axi_ctrl_pkg::AA_HIGH);

    always_comb begin
        if (in_mb) begin
            req.region = axi_ctrl_pkg::REGION_MB;
        end else if (in_aa) begin
            req.region = axi_ctrl_pkg::REGION_AA;
        end else if (head_write) begin
            req.region = axi_ctrl_pkg::REGION_IGNORE;
        end else begin
            // every other read answers all ones
            req.region = axi_ctrl_pkg::REGION_UNSUPP;
        end
    end

    a_one_strobe : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn) !(wstart && rstart)
    );

    a_strobe_not_full : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn) (wstart || rstart) |-> fifo_wr_rdy
    );

endmodule

`default_nettype wire

//--- verilog/ss_request_port.sv
// stream beat queue, two-beat write pairing and mailbox decode
`timescale 1ns/1ps
`default_nettype none

module ss_request_port #(
    parameter int FIFO_DEPTH = axi_ctrl_pkg::FIFO_DEPTH_DEFAULT
) (
    input  wire                      axi_aclk,
    input  wire                      axi_aresetn,
    input  wire axi_ctrl_pkg::word_t beat_data,
    input  wire [1:0]                beat_user,
    input  wire                      beat_valid,
    output logic                     beat_ready,
    ctrl_req_if.port                 req
);

    // entry layout {user, data}
    localparam int ENTRY_W = 2 + $bits(axi_ctrl_pkg::word_t);

    logic [ENTRY_W-1:0]  head;
    logic                head_vld;
    logic                head_pop;
    logic [1:0]          head_user;
    axi_ctrl_pkg::word_t head_data;
    logic                head_is_wr;
    logic                hold_vld;
    axi_ctrl_pkg::word_t hold_data;
    logic [27:0]         pair_addr;
    logic                in_win;

    req_fifo #(
        .WIDTH (ENTRY_W),
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wr_vld      (beat_valid && beat_ready),
        .wr_data     ({beat_user, beat_data}),
        .wr_rdy      (beat_ready),
        .rd_vld      (head_vld),
        .rd_data     (head),
        .rd_rdy      (head_pop)
    );

    assign {head_user, head_data} = head;
    assign head_is_wr = (head_user == axi_ctrl_pkg::SS_WR_USER);

    // junk beats and first write beats leave at once, second beat waits for taken
    assign head_pop = head_vld && (!head_is_wr || !hold_vld || req.taken);

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            hold_vld <= 1'b0;
        end else if (head_vld && head_is_wr) begin
            if (!hold_vld) begin
                hold_vld <= 1'b1;
            end else if (req.taken) begin
                hold_vld <= 1'b0;
            end
        end
    end

    // first beat: strobe in 31:28, address in 27:0
    always_ff @(posedge axi_aclk) begin
        if (head_vld && head_is_wr && !hold_vld) begin
            hold_data <= head_data;
        end
    end

    // ----------------------------------------
    // paired request
    // ----------------------------------------
    assign pair_addr = hold_data[27:0];
    assign in_win    = (pair_addr >= 28'(axi_ctrl_pkg::MB_LOW))
                    && (pair_addr <= 28'(axi_ctrl_pkg::WIN_HIGH));

    assign req.valid  = head_vld && head_is_wr && hold_vld;
    assign req.write  = 1'b1;
    assign req.strb   = hold_data[31:28];
    assign req.data   = head_data;
    assign req.index  = pair_addr[4:2];
    assign req.region = (in_win && (pair_addr <= 28'(axi_ctrl_pkg::MB_HIGH)))
                      ? axi_ctrl_pkg::REGION_MB : axi_ctrl_pkg::REGION_IGNORE;

endmodule

`default_nettype wire

//--- verilog/mailbox_engine.sv
// round-robin request engine with mailbox, AA registers, read answers and interrupt
`timescale 1ns/1ps
`default_nettype none

module mailbox_engine (
    input  wire                 axi_aclk,
    input  wire                 axi_aresetn,
    ctrl_req_if.engine          ls_req,
    ctrl_req_if.engine          ss_req,
    output axi_ctrl_pkg::word_t rdata,
    output logic                rdone,
    output logic                interrupt
);

    axi_ctrl_pkg::engine_state_t state;
    axi_ctrl_pkg::engine_state_t state_nxt;

    // side served last, also the side in service outside ST_IDLE
    logic                    last_ss;
    logic                    pick_ss;
    logic                    cur_write;
    axi_ctrl_pkg::region_t   cur_region;
    axi_ctrl_pkg::mb_index_t cur_index;
    axi_ctrl_pkg::word_t     cur_data;
    axi_ctrl_pkg::strb_t     cur_strb;
    axi_ctrl_pkg::word_t     mb_q [8];
    axi_ctrl_pkg::word_t     rd_value;
    axi_ctrl_pkg::word_t     rdata_q;
    logic                    int_en;
    logic                    int_sts;

    // local side wins ties when the stream side went last
    assign pick_ss = ss_req.valid && (!ls_req.valid || !last_ss);

    assign cur_write  = last_ss ? ss_req.write  : ls_req.write;
    assign cur_region = last_ss ? ss_req.region : ls_req.region;
    assign cur_index  = last_ss ? ss_req.index  : ls_req.index;
    assign cur_data   = last_ss ? ss_req.data   : ls_req.data;
    assign cur_strb   = last_ss ? ss_req.strb   : ls_req.strb;

    assign ls_req.taken = (state == axi_ctrl_pkg::ST_EXEC) && !last_ss;
    assign ss_req.taken = (state == axi_ctrl_pkg::ST_EXEC) && last_ss;

    assign rdata     = rdata_q;
    assign rdone     = (state == axi_ctrl_pkg::ST_RESPOND);
    assign interrupt = (state == axi_ctrl_pkg::ST_IRQ) && int_en;

    always_comb begin
        state_nxt = axi_ctrl_pkg::ST_IDLE;
        case (state)
            axi_ctrl_pkg::ST_IDLE: begin
                if (ls_req.valid || ss_req.valid) begin
                    state_nxt = axi_ctrl_pkg::ST_EXEC;
                end
            end
            axi_ctrl_pkg::ST_EXEC: begin
                if (!cur_write) begin
                    state_nxt = axi_ctrl_pkg::ST_RESPOND;
                end else if (last_ss && (cur_region == axi_ctrl_pkg::REGION_MB)) begin
                    state_nxt = axi_ctrl_pkg::ST_IRQ;
                end
            end
            default: state_nxt = axi_ctrl_pkg::ST_IDLE;
        endcase
    end

    // ----------------------------------------
    // read data select
    // ----------------------------------------
    always_comb begin
        case (cur_region)
            axi_ctrl_pkg::REGION_MB: rd_value = mb_q[cur_index];
            axi_ctrl_pkg::REGION_AA: begin
                // only bit 0 of offsets 0 and 1 exists
                if (cur_index == 3'd0) begin
                    rd_value = {31'b0, int_en};
                end else if (cur_index == 3'd1) begin
                    rd_value = {31'b0, int_sts};
                end else begin
                    rd_value = '0;
                end
            end
            default: rd_value = axi_ctrl_pkg::UNSUPP_DATA;
        endcase
    end

    always_ff @(posedge axi_aclk or negedge axi_aresetn) begin
        if (!axi_aresetn) begin
            state   <= axi_ctrl_pkg::ST_IDLE;
            last_ss <= 1'b1;
            int_en  <= 1'b0;
            int_sts <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                mb_q[i] <= '0;
            end
        end else begin
            state <= state_nxt;
            if (state == axi_ctrl_pkg::ST_IDLE && (ls_req.valid || ss_req.valid)) begin
                last_ss <= pick_ss;
            end
            if (state == axi_ctrl_pkg::ST_EXEC && cur_write) begin
                if (cur_region == axi_ctrl_pkg::REGION_MB) begin
                    for (int b = 0; b < 4; b++) begin
                        if (cur_strb[b]) begin
                            mb_q[cur_index][8*b +: 8] <= cur_data[8*b +: 8];
                        end
                    end
                end else if (cur_region == axi_ctrl_pkg::REGION_AA && cur_strb[0]) begin
                    if (cur_index == 3'd0) begin
                        int_en <= cur_data[0];
                    end else if (cur_index == 3'd1 && cur_data[0]) begin
                        // write 1 to clear
                        int_sts <= 1'b0;
                    end
                end
            end
            if (state == axi_ctrl_pkg::ST_IRQ && int_en) begin
                int_sts <= 1'b1;
            end
        end
    end

    always_ff @(posedge axi_aclk) begin
        if (state == axi_ctrl_pkg::ST_EXEC && !cur_write) begin
            rdata_q <= rd_value;
        end
    end

    // a request is only consumed while its port still shows it
    a_taken_when_valid : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        !(ls_req.taken && !ls_req.valid) && !(ss_req.taken && !ss_req.valid)
    );

    a_rdone_after_read : assert property (
        @(posedge axi_aclk) disable iff (!axi_aresetn)
        rdone |-> $past(ls_req.taken && !ls_req.write)
    );

endmodule

`default_nettype wire

//--- verilog/axi_ctrl_logic.sv
// bridge control top level with local and stream request ports and the engine
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_logic #(
    parameter int FIFO_DEPTH = axi_ctrl_pkg::FIFO_DEPTH_DEFAULT
) (
    input  wire                      axi_aclk,
    input  wire                      axi_aresetn,
    output logic                     axi_interrupt,

    // local register side
    input  wire                      bk_ls_wstart,
    input  wire axi_ctrl_pkg::addr_t bk_ls_waddr,
    input  wire axi_ctrl_pkg::word_t bk_ls_wdata,
    input  wire axi_ctrl_pkg::strb_t bk_ls_wstrb,
    input  wire                      bk_ls_rstart,
    input  wire axi_ctrl_pkg::addr_t bk_ls_raddr,
    output axi_ctrl_pkg::word_t      bk_ls_rdata,
    output logic                     bk_ls_rdone,

    // remote stream side
    input  wire axi_ctrl_pkg::word_t bk_ss_data,
    input  wire [1:0]                bk_ss_user,
    input  wire                      bk_ss_valid,
    output logic                     bk_ss_ready
);

    ctrl_req_if ls_req ();
    ctrl_req_if ss_req ();

    ls_request_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) ls_port_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .wstart      (bk_ls_wstart),
        .waddr       (bk_ls_waddr),
        .wdata       (bk_ls_wdata),
        .wstrb       (bk_ls_wstrb),
        .rstart      (bk_ls_rstart),
        .raddr       (bk_ls_raddr),
        .req         (ls_req.port)
    );

    ss_request_port #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) ss_port_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .beat_data   (bk_ss_data),
        .beat_user   (bk_ss_user),
        .beat_valid  (bk_ss_valid),
        .beat_ready  (bk_ss_ready),
        .req         (ss_req.port)
    );

    mailbox_engine engine_i (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ls_req      (ls_req.engine),
        .ss_req      (ss_req.engine),
        .rdata       (bk_ls_rdata),
        .rdone       (bk_ls_rdone),
        .interrupt   (axi_interrupt)
    );

endmodule

`default_nettype wire

//--- test/axi_ctrl_checker.sv
// response checker for read answers, interrupt pulses and stream ready, with error counters
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_checker (
    input  wire        axi_aclk,
    input  wire        axi_aresetn,
    input  wire [31:0] bk_ls_rdata,
    input  wire        bk_ls_rdone,
    input  wire        axi_interrupt,
    input  wire        bk_ss_ready
);

    string       name_q [$];
    logic [31:0] data_q [$];
    string       irq_name;
    int          irq_exp = 0;
    int          irq_seen = 0;
    bit          irq_open = 1'b0;
    int          data_errors = 0;
    int          irq_errors = 0;
    int          other_errors = 0;

    // reads are answered in request order
    task automatic expect_read(input string name, input logic [31:0] exp);
        name_q.push_back(name);
        data_q.push_back(exp);
    endtask

    function automatic int pending_reads();
        return data_q.size();
    endfunction

    task automatic open_irq_window(input string name, input int exp);
        irq_name = name;
        irq_exp  = exp;
        irq_seen = 0;
        irq_open = 1'b1;
    endtask

    task automatic close_irq_window();
        if (irq_open && irq_seen != irq_exp) begin
            irq_errors++;
            $display("Fail %s: expected %0d, actual %0d", irq_name, irq_exp, irq_seen);
        end
        irq_open = 1'b0;
    endtask

    // an empty stream queue must accept beats
    task automatic check_ready_high(input string name);
        if (bk_ss_ready !== 1'b1) begin
            other_errors++;
            $display("Fail %s: expected ready 1, actual %b", name, bk_ss_ready);
        end
    endtask

    task automatic report_missing();
        while (name_q.size() > 0) begin
            other_errors++;
            $display("no read answer arrived for %s", name_q.pop_front());
            void'(data_q.pop_front());
        end
    endtask

    task automatic report_error(input string msg);
        other_errors++;
        $display("%s", msg);
    endtask

    // ----------------------------------------
    // output monitor
    // ----------------------------------------
    always @(posedge axi_aclk) begin
        if (axi_aresetn && bk_ls_rdone) begin
            if (data_q.size() == 0) begin
                other_errors++;
                $display("unexpected read answer %08h with no read pending", bk_ls_rdata);
            end else if (bk_ls_rdata !== data_q[0]) begin
                data_errors++;
                $display("Fail %s: expected %08h, actual %08h", name_q[0], data_q[0],
                         bk_ls_rdata);
                void'(name_q.pop_front());
                void'(data_q.pop_front());
            end else begin
                void'(name_q.pop_front());
                void'(data_q.pop_front());
            end
        end
        if (axi_aresetn && axi_interrupt) begin
            if (irq_open) begin
                irq_seen++;
            end else begin
                other_errors++;
                $display("unexpected interrupt pulse outside a remote write");
            end
        end
    end

endmodule

`default_nettype wire

//--- test/axi_ctrl_logic_tb.sv
// testbench top with clock, reset, test file loader, stimulus tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module axi_ctrl_logic_tb;

    localparam int HALF_PERIOD = 4;

    logic        axi_aclk = 1'b0;
    logic        axi_aresetn = 1'b0;
    logic        axi_interrupt;
    logic        bk_ls_wstart = 1'b0;
    logic [14:0] bk_ls_waddr = '0;
    logic [31:0] bk_ls_wdata = '0;
    logic [3:0]  bk_ls_wstrb = '0;
    logic        bk_ls_rstart = 1'b0;
    logic [14:0] bk_ls_raddr = '0;
    logic [31:0] bk_ls_rdata;
    logic        bk_ls_rdone;
    logic [31:0] bk_ss_data = '0;
    logic [1:0]  bk_ss_user = '0;
    logic        bk_ss_valid = 1'b0;
    logic        bk_ss_ready;

    string       op_name [$];
    string       op_kind [$];
    logic [31:0] op_addr [$];
    logic [31:0] op_data [$];
    logic [31:0] op_strb [$];
    logic [31:0] op_exp [$];
    int          op_wait [$];
    int          n_ops = 0;
    bit          loaded = 1'b0;
    bit          file_ok;

    always #(HALF_PERIOD) axi_aclk = ~axi_aclk;

    axi_ctrl_logic dut_i (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .axi_interrupt (axi_interrupt),
        .bk_ls_wstart  (bk_ls_wstart),
        .bk_ls_waddr   (bk_ls_waddr),
        .bk_ls_wdata   (bk_ls_wdata),
        .bk_ls_wstrb   (bk_ls_wstrb),
        .bk_ls_rstart  (bk_ls_rstart),
        .bk_ls_raddr   (bk_ls_raddr),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ls_rdone   (bk_ls_rdone),
        .bk_ss_data    (bk_ss_data),
        .bk_ss_user    (bk_ss_user),
        .bk_ss_valid   (bk_ss_valid),
        .bk_ss_ready   (bk_ss_ready)
    );

    axi_ctrl_checker check_i (
        .axi_aclk      (axi_aclk),
        .axi_aresetn   (axi_aresetn),
        .bk_ls_rdata   (bk_ls_rdata),
        .bk_ls_rdone   (bk_ls_rdone),
        .axi_interrupt (axi_interrupt),
        .bk_ss_ready   (bk_ss_ready)
    );

    // ----------------------------------------
    // test file
    // ----------------------------------------
    task automatic load_tests(output bit ok);
        int          fd;
        int          cnt;
        string       line;
        string       name;
        string       kind;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] s;
        logic [31:0] e;
        int          w;
        ok = 1'b0;
        fd = $fopen("test/axi_ctrl_tests.txt", "r");
        if (fd != 0) begin
            ok = 1'b1;
            while ($fgets(line, fd) != 0) begin
                // skip comment lines
                if (line.len() > 0 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %s %h %h %h %h %d", name, kind, a, d, s, e, w);
                    if (cnt == 7) begin
                        op_name.push_back(name);
                        op_kind.push_back(kind);
                        op_addr.push_back(a);
                        op_data.push_back(d);
                        op_strb.push_back(s);
                        op_exp.push_back(e);
                        op_wait.push_back(w);
                    end
                end
            end
            $fclose(fd);
        end else begin
            $display("could not open the test data file");
        end
        n_ops = op_name.size();
        if (ok && n_ops == 0) begin
            ok = 1'b0;
            $display("the test data file holds no operations");
        end
    endtask

    // ----------------------------------------
    // stimulus, all on the falling edge
    // ----------------------------------------
    task automatic local_write(input logic [31:0] a, input logic [31:0] d,
                               input logic [31:0] s);
        bk_ls_wstart = 1'b1;
        bk_ls_waddr  = a[14:0];
        bk_ls_wdata  = d;
        bk_ls_wstrb  = s[3:0];
        @(negedge axi_aclk);
        bk_ls_wstart = 1'b0;
    endtask

    task automatic local_read(input logic [31:0] a);
        bk_ls_rstart = 1'b1;
        bk_ls_raddr  = a[14:0];
        @(negedge axi_aclk);
        bk_ls_rstart = 1'b0;
    endtask

    // ready only moves on a rising edge, so its value here holds for the next one
    task automatic send_beat(input logic [1:0] user, input logic [31:0] d);
        bk_ss_valid = 1'b1;
        bk_ss_user  = user;
        bk_ss_data  = d;
        while (!bk_ss_ready) begin
            @(negedge axi_aclk);
        end
        @(negedge axi_aclk);
        bk_ss_valid = 1'b0;
    endtask

    task automatic settle(input string name);
        int guard;
        guard = 0;
        while (check_i.pending_reads() > 0 && guard < 40) begin
            @(negedge axi_aclk);
            guard++;
        end
        if (check_i.pending_reads() > 0) begin
            check_i.report_missing();
        end
        repeat (12) @(negedge axi_aclk);
        check_i.close_irq_window();
        check_i.check_ready_high(name);
    endtask

    task automatic run_op(input int i);
        if (op_kind[i] == "LSW") begin
            local_write(op_addr[i], op_data[i], op_strb[i]);
        end else if (op_kind[i] == "LSR") begin
            check_i.expect_read(op_name[i], op_exp[i]);
            local_read(op_addr[i]);
        end else if (op_kind[i] == "SSW") begin
            check_i.open_irq_window(op_name[i], op_exp[i]);
            send_beat(2'b01, {op_strb[i][3:0], op_addr[i][27:0]});
            send_beat(2'b01, op_data[i]);
        end else if (op_kind[i] == "SSX") begin
            send_beat(2'b10, op_data[i]);
        end else begin
            check_i.report_error({"unknown operation in test ", op_name[i]});
        end
        if (op_wait[i] != 0) begin
            settle(op_name[i]);
        end
    endtask

    task automatic finish_run(input bit ok);
        int total;
        total = check_i.data_errors + check_i.irq_errors + check_i.other_errors;
        $display("errors: %0d data, %0d interrupt, %0d other, %0d operations run",
                 check_i.data_errors, check_i.irq_errors, check_i.other_errors, n_ops);
        if (ok && total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        load_tests(file_ok);
        loaded = 1'b1;
        repeat (3) @(posedge axi_aclk);
        @(negedge axi_aclk);
        axi_aresetn = 1'b1;
        check_i.check_ready_high("reset_idle");
        if (file_ok) begin
            for (int i = 0; i < n_ops; i++) begin
                run_op(i);
            end
            settle("final_idle");
        end
        finish_run(file_ok);
    end

    // watchdog, scaled by the number of operations
    initial begin
        wait (loaded);
        repeat ((n_ops + 1) * 40) @(posedge axi_aclk);
        $display("timeout: the run did not finish within %0d cycles", (n_ops + 1) * 40);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/axi_ctrl_tests.txt
# name op addr data strb expect wait (hex fields, wait is 0 or 1)
# expect is read data for LSR and the interrupt pulse count for SSW
t1_mb_init   LSW 2004 11223344 f 0 1
t1_mb_mixed  LSW 2004 aabbccdd 5 0 1
t1_mb_read   LSR 2004 0 0 11bb33dd 1
t2_unsupp_hi LSR 2200 0 0 ffffffff 1
t2_unsupp_lo LSR 0100 0 0 ffffffff 1
t2_ign_write LSW 2300 deadbeef f 0 1
t2_mb0_read  LSR 2000 0 0 00000000 1
t3_en_write  LSW 2100 00000001 f 0 1
t3_en_read   LSR 2100 0 0 00000001 1
t3_ss_irq    SSW 2008 12345678 f 1 1
t3_sts_read  LSR 2104 0 0 00000001 1
t3_sts_clear LSW 2104 00000001 1 0 1
t3_sts_zero  LSR 2104 0 0 00000000 1
t4_en_off    LSW 2100 00000000 f 0 1
t4_ss_noirq  SSW 200c cafef00d f 0 1
t4_mb3_read  LSR 200c 0 0 cafef00d 1
t4_mb2_read  LSR 2008 0 0 12345678 1
t5_junk      SSX 0 f0002010 0 0 0
t5_ss_write  SSW 2010 55667788 3 0 1
t5_mb4_read  LSR 2010 0 0 00007788 1
t6_wr0       LSW 2014 01010101 f 0 0
t6_wr1       LSW 2018 02020202 f 0 0
t6_rd0       LSR 2014 0 0 01010101 0
t6_rd1       LSR 2018 0 0 02020202 0
t6_rd_en     LSR 2100 0 0 00000000 0
t6_rd2       LSR 201c 0 0 00000000 1

//--- axi_ctrl_logic.f
verilog/axi_ctrl_pkg.sv
verilog/ctrl_req_if.sv
verilog/req_fifo.sv
verilog/ls_request_port.sv
verilog/ss_request_port.sv
verilog/mailbox_engine.sv
verilog/axi_ctrl_logic.sv
test/axi_ctrl_checker.sv
test/axi_ctrl_logic_tb.sv

//--- Bender.yml
package:
  name: axi_ctrl_logic

sources:
  - verilog/axi_ctrl_pkg.sv
  - verilog/ctrl_req_if.sv
  - verilog/req_fifo.sv
  - verilog/ls_request_port.sv
  - verilog/ss_request_port.sv
  - verilog/mailbox_engine.sv
  - verilog/axi_ctrl_logic.sv
  - target: test
    files:
      - test/axi_ctrl_checker.sv
      - test/axi_ctrl_logic_tb.sv
